// File: hdl/coh_mem_pkg.sv
//--------------------------------------------------------------------------
// shared sizes and encodings of the snooping MSI memory controller
// bus message and memory command codes are referenced by scoped name
// from every module of the memory side and from the testbench
//--------------------------------------------------------------------------
`default_nettype none

package coh_mem_pkg;

	//------------------------------------------------------------------------
	// sizes
	localparam int LINE_NUM   = 16;  // memory lines, index only
	localparam int LINE_IDX_W = 4;
	localparam int DATA_W     = 64;  // one word per line
	localparam int MSHR_NUM   = 4;   // depth of issue and response queues
	localparam int MSHR_IDX_W = 2;
	localparam int PTR_W      = 3;   // bus response queue pointer
	localparam int MEM_TAG_W  = 4;   // tag 0 = no response

	// cycles from a load ack to its data
	localparam int MEM_LATENCY = 4;

	//------------------------------------------------------------------------
	// encodings
	typedef enum logic [1:0] {
		MSG_NONE  = 2'd0,
		MSG_GET_S = 2'd1,
		MSG_GET_M = 2'd2,
		MSG_PUT_M = 2'd3
	} bus_msg_e;

	typedef enum logic [1:0] {
		CMD_NONE  = 2'd0,
		CMD_LOAD  = 2'd1,
		CMD_STORE = 2'd2
	} mem_cmd_e;

endpackage

`default_nettype wire

// File: hdl/coh_line_dir.sv
//--------------------------------------------------------------------------
// per-line directory of the memory controller
// keeps valid and dirty bits for every line, acks bus requests in the
// same cycle and asks the issue queue for load or store entries
//--------------------------------------------------------------------------
`default_nettype none

module coh_line_dir (
	input  logic                                clk,
	input  logic                                rst,
	input  coh_mem_pkg::bus_msg_e               bus_req_msg_i,
	input  logic [coh_mem_pkg::LINE_IDX_W-1:0]  bus_req_idx_i,
	input  logic                                iss_full_i,
	output logic                                bus_req_ack_o,
	output logic                                alloc_o,
	output logic                                alloc_store_o
);

	// I: !vld, S: vld & !dty, M: dty
	logic [coh_mem_pkg::LINE_NUM-1:0] vld_r;
	logic [coh_mem_pkg::LINE_NUM-1:0] dty_r;

	logic line_vld;
	logic line_dty;
	logic nxt_vld;
	logic nxt_dty;

	assign line_vld = vld_r[bus_req_idx_i];
	assign line_dty = dty_r[bus_req_idx_i];

	//------------------------------------------------------------------------
	// request decode
	always_comb begin
		bus_req_ack_o = 1'b0;
		alloc_o       = 1'b0;
		alloc_store_o = 1'b0;
		nxt_vld       = line_vld;
		nxt_dty       = line_dty;
		if (line_dty) begin
			// owner holds newer data, memory waits for the write-back
			if (bus_req_msg_i == coh_mem_pkg::MSG_PUT_M && !iss_full_i) begin
				bus_req_ack_o = 1'b1;  // M -> I
				alloc_o       = 1'b1;
				alloc_store_o = 1'b1;
				nxt_vld       = 1'b0;
				nxt_dty       = 1'b0;
			end else if (bus_req_msg_i == coh_mem_pkg::MSG_GET_S && !iss_full_i) begin
				bus_req_ack_o = 1'b1;  // M -> S
				alloc_o       = 1'b1;
				alloc_store_o = 1'b1;
				nxt_dty       = 1'b0;
			end
		end else if (line_vld) begin
			if (bus_req_msg_i == coh_mem_pkg::MSG_GET_M) begin
				bus_req_ack_o = 1'b1;  // upgrade, no data from memory
				nxt_dty       = 1'b1;
			end
		end else begin
			if (bus_req_msg_i == coh_mem_pkg::MSG_GET_S && !iss_full_i) begin
				bus_req_ack_o = 1'b1;  // I -> S, memory sends data
				alloc_o       = 1'b1;
				nxt_vld       = 1'b1;
			end else if (bus_req_msg_i == coh_mem_pkg::MSG_GET_M) begin
				bus_req_ack_o = 1'b1;  // I -> M
				nxt_vld       = 1'b1;
				nxt_dty       = 1'b1;
			end
		end
	end

	// state moves only on ack
	always_ff @(posedge clk) begin
		if (rst) begin
			vld_r <= '0;
			dty_r <= '0;
		end else if (bus_req_ack_o) begin
			vld_r[bus_req_idx_i] <= nxt_vld;
			dty_r[bus_req_idx_i] <= nxt_dty;
		end
	end

endmodule

`default_nettype wire

// File: hdl/mem_issue_q.sv
//--------------------------------------------------------------------------
// in-order issue queue towards the backing memory
// loads are ready on allocation, stores wait for their write-back data;
// only a ready head entry is offered, and a nonzero ack tag retires it
//--------------------------------------------------------------------------
`default_nettype none

module mem_issue_q (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                alloc_i,
	input  logic                                alloc_store_i,
	input  logic [coh_mem_pkg::LINE_IDX_W-1:0]  alloc_idx_i,
	input  logic [coh_mem_pkg::PTR_W-1:0]       alloc_ptr_i,
	input  logic                                wb_vld_i,
	input  logic [coh_mem_pkg::LINE_IDX_W-1:0]  wb_idx_i,
	input  logic [coh_mem_pkg::DATA_W-1:0]      wb_data_i,
	input  logic                                rsp_full_i,
	input  logic [coh_mem_pkg::MEM_TAG_W-1:0]   mem_ack_tag_i,
	output logic                                full_o,
	output coh_mem_pkg::mem_cmd_e               mem_cmd_o,
	output logic [coh_mem_pkg::LINE_IDX_W-1:0]  mem_idx_o,
	output logic [coh_mem_pkg::DATA_W-1:0]      mem_data_o,
	output logic                                iss_load_o,
	output logic [coh_mem_pkg::PTR_W-1:0]       iss_ptr_o
);

	logic [coh_mem_pkg::MSHR_NUM-1:0]     vld_r;
	logic [coh_mem_pkg::MSHR_NUM-1:0]     rdy_r;  // 0 while waiting for data
	coh_mem_pkg::mem_cmd_e                cmd_r  [coh_mem_pkg::MSHR_NUM];
	logic [coh_mem_pkg::LINE_IDX_W-1:0]   idx_r  [coh_mem_pkg::MSHR_NUM];
	logic [coh_mem_pkg::DATA_W-1:0]       data_r [coh_mem_pkg::MSHR_NUM];
	logic [coh_mem_pkg::PTR_W-1:0]        ptr_r  [coh_mem_pkg::MSHR_NUM];

	// msb of each pointer is the wrap bit
	logic [coh_mem_pkg::MSHR_IDX_W:0]     head_r;
	logic [coh_mem_pkg::MSHR_IDX_W:0]     tail_r;
	logic [coh_mem_pkg::MSHR_IDX_W-1:0]   head;
	logic [coh_mem_pkg::MSHR_IDX_W-1:0]   tail;

	logic                                 head_go;
	logic                                 pop;
	logic [coh_mem_pkg::MSHR_NUM-1:0]     wb_hit;

	assign head   = head_r[coh_mem_pkg::MSHR_IDX_W-1:0];
	assign tail   = tail_r[coh_mem_pkg::MSHR_IDX_W-1:0];
	assign full_o = (head_r[coh_mem_pkg::MSHR_IDX_W] != tail_r[coh_mem_pkg::MSHR_IDX_W]) &&
	                (head == tail);

	//------------------------------------------------------------------------
	// head presentation, loads hold back while the response queue is full
	assign head_go    = vld_r[head] && rdy_r[head] &&
	                    !(cmd_r[head] == coh_mem_pkg::CMD_LOAD && rsp_full_i);
	assign mem_cmd_o  = head_go ? cmd_r[head] : coh_mem_pkg::CMD_NONE;
	assign mem_idx_o  = idx_r[head];
	assign mem_data_o = data_r[head];

	assign pop        = head_go && (mem_ack_tag_i != '0);
	assign iss_load_o = pop && (cmd_r[head] == coh_mem_pkg::CMD_LOAD);
	assign iss_ptr_o  = ptr_r[head];

	// write-back matches every waiting entry of that line
	always_comb begin
		for (int i = 0; i < coh_mem_pkg::MSHR_NUM; i++) begin
			wb_hit[i] = wb_vld_i && vld_r[i] && !rdy_r[i] && (idx_r[i] == wb_idx_i);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_r  <= '0;
			rdy_r  <= '0;
			head_r <= '0;
			tail_r <= '0;
		end else begin
			rdy_r <= rdy_r | wb_hit;
			if (pop) begin
				vld_r[head] <= 1'b0;
				head_r      <= head_r + 1'b1;
			end
			if (alloc_i) begin
				vld_r[tail] <= 1'b1;
				rdy_r[tail] <= !alloc_store_i;  // load goes out without data
				tail_r      <= tail_r + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < coh_mem_pkg::MSHR_NUM; i++) begin
			if (wb_hit[i])
				data_r[i] <= wb_data_i;
		end
		if (alloc_i) begin
			cmd_r[tail] <= alloc_store_i ? coh_mem_pkg::CMD_STORE : coh_mem_pkg::CMD_LOAD;
			idx_r[tail] <= alloc_idx_i;
			ptr_r[tail] <= alloc_ptr_i;
		end
	end

endmodule

`default_nettype wire

// File: hdl/mem_rsp_q.sv
//--------------------------------------------------------------------------
// response queue of outstanding loads
// holds memory tag and bus pointer in issue order; returning data whose
// tag matches the head goes to the bus with the stored pointer
//--------------------------------------------------------------------------
`default_nettype none

module mem_rsp_q (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                push_i,
	input  logic [coh_mem_pkg::MEM_TAG_W-1:0]   push_tag_i,
	input  logic [coh_mem_pkg::PTR_W-1:0]       push_ptr_i,
	input  logic [coh_mem_pkg::MEM_TAG_W-1:0]   rd_tag_i,
	input  logic [coh_mem_pkg::DATA_W-1:0]      rd_data_i,
	output logic                                full_o,
	output logic                                rsp_vld_o,
	output logic [coh_mem_pkg::PTR_W-1:0]       rsp_ptr_o,
	output logic [coh_mem_pkg::DATA_W-1:0]      rsp_data_o
);

	logic [coh_mem_pkg::MEM_TAG_W-1:0]    tag_r [coh_mem_pkg::MSHR_NUM];
	logic [coh_mem_pkg::PTR_W-1:0]        ptr_r [coh_mem_pkg::MSHR_NUM];
	logic [coh_mem_pkg::MSHR_IDX_W:0]     head_r;  // msb wraps
	logic [coh_mem_pkg::MSHR_IDX_W:0]     tail_r;
	logic [coh_mem_pkg::MSHR_IDX_W-1:0]   head;
	logic [coh_mem_pkg::MSHR_IDX_W-1:0]   tail;
	logic                                 empty;

	assign head   = head_r[coh_mem_pkg::MSHR_IDX_W-1:0];
	assign tail   = tail_r[coh_mem_pkg::MSHR_IDX_W-1:0];
	assign empty  = (head_r == tail_r);
	assign full_o = (head_r[coh_mem_pkg::MSHR_IDX_W] != tail_r[coh_mem_pkg::MSHR_IDX_W]) &&
	                (head == tail);

	// tag 0 never matches
	assign rsp_vld_o  = !empty && (rd_tag_i != '0) && (rd_tag_i == tag_r[head]);
	assign rsp_ptr_o  = ptr_r[head];
	assign rsp_data_o = rd_data_i;  // data is not stored

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
		end else begin
			if (rsp_vld_o)
				head_r <= head_r + 1'b1;
			if (push_i)
				tail_r <= tail_r + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push_i) begin
			tag_r[tail] <= push_tag_i;
			ptr_r[tail] <= push_ptr_i;
		end
	end

endmodule

`default_nettype wire

// File: hdl/tagged_dmem.sv
//--------------------------------------------------------------------------
// backing data memory with tagged responses
// every command is acked in its cycle with a nonzero tag from 1 to 15;
// load data follows MEM_LATENCY cycles later on the read tag and data
//--------------------------------------------------------------------------
`default_nettype none

module tagged_dmem (
	input  logic                                clk,
	input  logic                                rst,
	input  coh_mem_pkg::mem_cmd_e               cmd_i,
	input  logic [coh_mem_pkg::LINE_IDX_W-1:0]  idx_i,
	input  logic [coh_mem_pkg::DATA_W-1:0]      data_i,
	output logic [coh_mem_pkg::MEM_TAG_W-1:0]   ack_tag_o,
	output logic [coh_mem_pkg::MEM_TAG_W-1:0]   rd_tag_o,
	output logic [coh_mem_pkg::DATA_W-1:0]      rd_data_o
);

	logic [coh_mem_pkg::DATA_W-1:0]       mem_r       [coh_mem_pkg::LINE_NUM];
	logic [coh_mem_pkg::MEM_TAG_W-1:0]    tag_cnt_r;
	logic [coh_mem_pkg::MEM_TAG_W-1:0]    pipe_tag_r  [coh_mem_pkg::MEM_LATENCY];
	logic [coh_mem_pkg::DATA_W-1:0]       pipe_data_r [coh_mem_pkg::MEM_LATENCY];

	assign ack_tag_o = (cmd_i != coh_mem_pkg::CMD_NONE) ? tag_cnt_r : '0;
	assign rd_tag_o  = pipe_tag_r[coh_mem_pkg::MEM_LATENCY-1];
	assign rd_data_o = pipe_data_r[coh_mem_pkg::MEM_LATENCY-1];

	//------------------------------------------------------------------------
	// tag counter and tag pipeline, a zero tag is an empty slot
	always_ff @(posedge clk) begin
		if (rst) begin
			tag_cnt_r <= 1;
			for (int i = 0; i < coh_mem_pkg::MEM_LATENCY; i++) begin
				pipe_tag_r[i] <= '0;
			end
		end else begin
			if (cmd_i != coh_mem_pkg::CMD_NONE)
				tag_cnt_r <= (tag_cnt_r == '1) ? 1 : tag_cnt_r + 1'b1;  // skip 0
			pipe_tag_r[0] <= (cmd_i == coh_mem_pkg::CMD_LOAD) ? tag_cnt_r : '0;
			for (int i = 1; i < coh_mem_pkg::MEM_LATENCY; i++) begin
				pipe_tag_r[i] <= pipe_tag_r[i-1];
			end
		end
	end

	// array and data pipeline
	always_ff @(posedge clk) begin
		pipe_data_r[0] <= mem_r[idx_i];
		for (int i = 1; i < coh_mem_pkg::MEM_LATENCY; i++) begin
			pipe_data_r[i] <= pipe_data_r[i-1];
		end
		if (rst) begin
			// line index repeated in every byte
			for (int i = 0; i < coh_mem_pkg::LINE_NUM; i++) begin
				mem_r[i] <= {(coh_mem_pkg::DATA_W/8){8'(i)}};
			end
		end else if (cmd_i == coh_mem_pkg::CMD_STORE) begin
			mem_r[idx_i] <= data_i;
		end
	end

endmodule

`default_nettype wire

// File: hdl/coh_mem_top.sv
//--------------------------------------------------------------------------
// memory side of the snooping MSI system
// joins line directory, issue queue, response queue and backing memory;
// the bus side is driven by the caches and the arbiter around it
//--------------------------------------------------------------------------
`default_nettype none

module coh_mem_top (
	input  logic                                clk,
	input  logic                                rst,
	// bus request
	input  coh_mem_pkg::bus_msg_e               bus_req_msg_i,
	input  logic [coh_mem_pkg::LINE_IDX_W-1:0]  bus_req_idx_i,
	input  logic [coh_mem_pkg::PTR_W-1:0]       bus_req_ptr_i,
	input  logic [coh_mem_pkg::DATA_W-1:0]      bus_req_data_i,  // request data phase, not read here
	output logic                                bus_req_ack_o,
	// write-back from the owning cache
	input  logic                                bus_wb_vld_i,
	input  logic [coh_mem_pkg::LINE_IDX_W-1:0]  bus_wb_idx_i,
	input  logic [coh_mem_pkg::DATA_W-1:0]      bus_wb_data_i,
	// data response
	output logic                                bus_rsp_vld_o,
	output logic [coh_mem_pkg::PTR_W-1:0]       bus_rsp_ptr_o,
	output logic [coh_mem_pkg::DATA_W-1:0]      bus_rsp_data_o
);

	logic                                 iss_full;
	logic                                 alloc;
	logic                                 alloc_store;
	logic                                 iss_load;
	logic [coh_mem_pkg::PTR_W-1:0]        iss_ptr;
	logic                                 rsp_full;
	coh_mem_pkg::mem_cmd_e                mem_cmd;
	logic [coh_mem_pkg::LINE_IDX_W-1:0]   mem_idx;
	logic [coh_mem_pkg::DATA_W-1:0]       mem_data;
	logic [coh_mem_pkg::MEM_TAG_W-1:0]    mem_ack_tag;
	logic [coh_mem_pkg::MEM_TAG_W-1:0]    mem_rd_tag;
	logic [coh_mem_pkg::DATA_W-1:0]       mem_rd_data;

	coh_line_dir u_dir (
		.clk           (clk),
		.rst           (rst),
		.bus_req_msg_i (bus_req_msg_i),
		.bus_req_idx_i (bus_req_idx_i),
		.iss_full_i    (iss_full),
		.bus_req_ack_o (bus_req_ack_o),
		.alloc_o       (alloc),
		.alloc_store_o (alloc_store)
	);

	mem_issue_q u_iss_q (
		.clk           (clk),
		.rst           (rst),
		.alloc_i       (alloc),
		.alloc_store_i (alloc_store),
		.alloc_idx_i   (bus_req_idx_i),
		.alloc_ptr_i   (bus_req_ptr_i),
		.wb_vld_i      (bus_wb_vld_i),
		.wb_idx_i      (bus_wb_idx_i),
		.wb_data_i     (bus_wb_data_i),
		.rsp_full_i    (rsp_full),
		.mem_ack_tag_i (mem_ack_tag),
		.full_o        (iss_full),
		.mem_cmd_o     (mem_cmd),
		.mem_idx_o     (mem_idx),
		.mem_data_o    (mem_data),
		.iss_load_o    (iss_load),
		.iss_ptr_o     (iss_ptr)
	);

	mem_rsp_q u_rsp_q (
		.clk        (clk),
		.rst        (rst),
		.push_i     (iss_load),
		.push_tag_i (mem_ack_tag),  // tag of the load just acked
		.push_ptr_i (iss_ptr),
		.rd_tag_i   (mem_rd_tag),
		.rd_data_i  (mem_rd_data),
		.full_o     (rsp_full),
		.rsp_vld_o  (bus_rsp_vld_o),
		.rsp_ptr_o  (bus_rsp_ptr_o),
		.rsp_data_o (bus_rsp_data_o)
	);

	tagged_dmem u_dmem (
		.clk       (clk),
		.rst       (rst),
		.cmd_i     (mem_cmd),
		.idx_i     (mem_idx),
		.data_i    (mem_data),
		.ack_tag_o (mem_ack_tag),
		.rd_tag_o  (mem_rd_tag),
		.rd_data_o (mem_rd_data)
	);

endmodule

`default_nettype wire

// File: tb/coh_mem_chk.sv
//--------------------------------------------------------------------------
// protocol checker bound into the memory side top level
// watches the bus request ack and the data response valid
//--------------------------------------------------------------------------
`default_nettype none

module coh_mem_chk (
	input  logic                   clk,
	input  logic                   rst,
	input  coh_mem_pkg::bus_msg_e  bus_req_msg_i,
	input  logic                   bus_req_ack_i,
	input  logic                   bus_rsp_vld_i
);
	timeunit 1ns;
	timeprecision 100ps;

	int   fail_cnt = 0;
	logic seen_ack;
	int   since_ack;  // saturates at MEM_LATENCY

	always @(posedge clk) begin
		if (rst) begin
			seen_ack  <= 1'b0;
			since_ack <= 0;
		end else if (!seen_ack) begin
			if (bus_req_ack_i)
				seen_ack <= 1'b1;
		end else if (since_ack < coh_mem_pkg::MEM_LATENCY) begin
			since_ack <= since_ack + 1;
		end
	end

	no_ack_on_none: assert property (@(posedge clk) disable iff (rst)
		bus_req_msg_i == coh_mem_pkg::MSG_NONE |-> !bus_req_ack_i)
		else begin
			$error("bus request acked with no message on the bus");
			fail_cnt++;
		end

	rsp_idle_after_rst: assert property (@(posedge clk) $fell(rst) |-> !bus_rsp_vld_i)
		else begin
			$error("response valid in the first cycle after reset");
			fail_cnt++;
		end

	// data needs the memory latency after the first load ack
	rsp_not_early: assert property (@(posedge clk) disable iff (rst)
		$rose(bus_rsp_vld_i) |-> seen_ack && since_ack >= coh_mem_pkg::MEM_LATENCY)
		else begin
			$error("response valid before the memory latency after the first ack");
			fail_cnt++;
		end

endmodule

bind coh_mem_top coh_mem_chk u_chk (
	.clk           (clk),
	.rst           (rst),
	.bus_req_msg_i (bus_req_msg_i),
	.bus_req_ack_i (bus_req_ack_o),
	.bus_rsp_vld_i (bus_rsp_vld_o)
);

`default_nettype wire

// File: tb/coh_mem_tb.sv
//--------------------------------------------------------------------------
// testbench of the memory side of the MSI system
// plays the caches and the bus arbiter with seeded random requests and
// write-backs, and checks acks and responses against a model
//--------------------------------------------------------------------------
`default_nettype none

module coh_mem_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_REQ     = 200;
	localparam int TIMEOUT_CYC = NUM_REQ * 40;  // 3 hold cycles per request plus drain
	localparam int ST_I        = 0;
	localparam int ST_S        = 1;
	localparam int ST_M        = 2;

	logic                                clk;
	logic                                rst;
	coh_mem_pkg::bus_msg_e               req_msg;
	logic [coh_mem_pkg::LINE_IDX_W-1:0]  req_idx;
	logic [coh_mem_pkg::PTR_W-1:0]       req_ptr;
	logic [coh_mem_pkg::DATA_W-1:0]      req_data;
	logic                                req_ack;
	logic                                wb_vld;
	logic [coh_mem_pkg::LINE_IDX_W-1:0]  wb_idx;
	logic [coh_mem_pkg::DATA_W-1:0]      wb_data;
	logic                                rsp_vld;
	logic [coh_mem_pkg::PTR_W-1:0]       rsp_ptr;
	logic [coh_mem_pkg::DATA_W-1:0]      rsp_data;

	integer seed   = 32'h11ad;
	int     cyc    = 0;

	//------------------------------------------------------------------------
	// model state
	int     line_st [coh_mem_pkg::LINE_NUM];
	int     last_st [coh_mem_pkg::LINE_NUM];  // newest store entry per line, -1 none
	int     iq_id [$];     // issue entries not yet known to be freed
	int     front_since;   // first cycle the oldest entry may sit at the head
	int     n_ent = 0;
	bit     ent_st    [NUM_REQ];
	int     ent_idx   [NUM_REQ];
	int     alloc_cyc [NUM_REQ];
	int     wb_cyc    [NUM_REQ];  // -1 while a store waits for data
	logic [coh_mem_pkg::DATA_W-1:0] st_data [NUM_REQ];
	logic [coh_mem_pkg::PTR_W-1:0]  exp_ptr [$];
	int     exp_src [$];
	int     exp_idx [$];

	// write-back supply, one slot per cycle
	bit                                 wb_due      [TIMEOUT_CYC + 64];
	logic [coh_mem_pkg::LINE_IDX_W-1:0] wb_due_idx  [TIMEOUT_CYC + 64];
	logic [coh_mem_pkg::DATA_W-1:0]     wb_due_data [TIMEOUT_CYC + 64];
	int                                 wb_left = 0;

	coh_mem_top DUT (
		.clk            (clk),
		.rst            (rst),
		.bus_req_msg_i  (req_msg),
		.bus_req_idx_i  (req_idx),
		.bus_req_ptr_i  (req_ptr),
		.bus_req_data_i (req_data),
		.bus_req_ack_o  (req_ack),
		.bus_wb_vld_i   (wb_vld),
		.bus_wb_idx_i   (wb_idx),
		.bus_wb_data_i  (wb_data),
		.bus_rsp_vld_o  (rsp_vld),
		.bus_rsp_ptr_o  (rsp_ptr),
		.bus_rsp_data_o (rsp_data)
	);

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("*** FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	// memory contents after reset, the line index in every byte
	function automatic logic [coh_mem_pkg::DATA_W-1:0] reset_word(input int idx);
		logic [coh_mem_pkg::DATA_W-1:0] w;
		w = '0;
		for (int b = 0; b < coh_mem_pkg::DATA_W / 8; b++)
			w[8*b +: 8] = idx[7:0];
		return w;
	endfunction

	// a ready store at the head leaves one cycle later
	task automatic retire_stores(input int now);
		while (iq_id.size() > 0 && ent_st[iq_id[0]] && wb_cyc[iq_id[0]] >= 0 &&
		       now >= wb_cyc[iq_id[0]] + 2 && now >= front_since + 1) begin
			void'(iq_id.pop_front());
			front_since = now;
		end
	endtask

	task automatic schedule_wb(input int now, input int idx);
		int d;
		d = now + 1 + ({$random(seed)} % 6);
		while (wb_due[d])
			d++;
		wb_due[d]      = 1'b1;
		wb_due_idx[d]  = idx;
		wb_due_data[d] = {$random(seed), $random(seed)};
		wb_left++;
	endtask

	// every waiting store of the line takes the data
	task automatic take_wb(input int now);
		foreach (iq_id[k]) begin
			if (ent_st[iq_id[k]] && wb_cyc[iq_id[k]] < 0 && ent_idx[iq_id[k]] == wb_idx) begin
				st_data[iq_id[k]] = wb_data;
				wb_cyc[iq_id[k]]  = now;
			end
		end
	endtask

	task automatic check_rsp(input int now);
		logic [coh_mem_pkg::PTR_W-1:0]  ptr;
		logic [coh_mem_pkg::DATA_W-1:0] exp_data;
		int src;
		int idx;
		assert (exp_ptr.size() > 0)
			else stop_on_error("response arrived while no load was outstanding");
		ptr = exp_ptr.pop_front();
		src = exp_src.pop_front();
		idx = exp_idx.pop_front();
		exp_data = (src < 0) ? reset_word(idx) : st_data[src];
		assert (rsp_ptr == ptr)
			else stop_on_error($sformatf("FAILED rsp_ptr expected %0d actual %0d", ptr, rsp_ptr));
		assert (rsp_data == exp_data)
			else stop_on_error($sformatf("FAILED rsp_data line %0d expected %h actual %h",
			                             idx, exp_data, rsp_data));
		// in order, so everything up to the oldest load has left the issue queue
		while (iq_id.size() > 0 && ent_st[iq_id[0]])
			void'(iq_id.pop_front());
		if (iq_id.size() > 0)
			void'(iq_id.pop_front());
		front_since = now;
	endtask

	//------------------------------------------------------------------------
	// ack decision with issue queue occupancy bounds
	task automatic check_ack(input int now);
		int idx;
		int st;
		int id;
		int k;
		int lo;
		bit legal;
		bit need;
		bit must;
		bit sure;
		idx   = req_idx;
		st    = line_st[idx];
		legal = (st == ST_I && (req_msg == coh_mem_pkg::MSG_GET_S ||
		                        req_msg == coh_mem_pkg::MSG_GET_M)) ||
		        (st == ST_S && req_msg == coh_mem_pkg::MSG_GET_M) ||
		        (st == ST_M && (req_msg == coh_mem_pkg::MSG_PUT_M ||
		                        req_msg == coh_mem_pkg::MSG_GET_S));
		need  = legal && req_msg != coh_mem_pkg::MSG_GET_M;
		// entries from the first one surely present onwards are all present
		k = iq_id.size();
		for (int j = iq_id.size() - 1; j >= 0; j--) begin
			id = iq_id[j];
			if (alloc_cyc[id] >= now - 1 ||
			    (ent_st[id] && (wb_cyc[id] < 0 || now <= wb_cyc[id] + 1)))
				k = j;
		end
		lo   = iq_id.size() - k;
		must = legal && !(need && lo >= coh_mem_pkg::MSHR_NUM);
		sure = !need || iq_id.size() < coh_mem_pkg::MSHR_NUM || lo >= coh_mem_pkg::MSHR_NUM;
		assert (!sure || req_ack == must)
			else stop_on_error($sformatf(
				"FAILED ack_decision line %0d msg %s state %0d expected %0b actual %0b",
				idx, req_msg.name(), st, must, req_ack));
		if (req_ack) begin
			if (req_msg == coh_mem_pkg::MSG_GET_M)
				line_st[idx] = ST_M;
			else if (req_msg == coh_mem_pkg::MSG_GET_S)
				line_st[idx] = ST_S;
			else
				line_st[idx] = ST_I;
			if (need) begin
				id            = n_ent++;
				ent_st[id]    = (st == ST_M);
				ent_idx[id]   = idx;
				alloc_cyc[id] = now;
				wb_cyc[id]    = -1;
				if (iq_id.size() == 0)
					front_since = now + 1;
				iq_id.push_back(id);
				if (ent_st[id]) begin
					last_st[idx] = id;
					schedule_wb(now, idx);
				end else begin
					exp_ptr.push_back(req_ptr);
					exp_src.push_back(last_st[idx]);
					exp_idx.push_back(idx);
				end
			end
		end
	endtask

	//------------------------------------------------------------------------
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	// sampled mid cycle, inputs settled
	always @(negedge clk) begin
		if (!rst) begin
			assert (cyc < TIMEOUT_CYC)
				else stop_on_error($sformatf("timeout with %0d responses still expected",
				                             exp_ptr.size()));
			assert (DUT.u_chk.fail_cnt == 0)
				else stop_on_error("bound checker reported a failed assertion");
			retire_stores(cyc);
			if (rsp_vld)
				check_rsp(cyc);
			if (wb_vld)
				take_wb(cyc);
			check_ack(cyc);
		end
	end

	initial begin
		wb_vld  = 1'b0;
		wb_idx  = '0;
		wb_data = '0;
		forever begin
			@(posedge clk);
			#2;
			wb_vld = wb_due[cyc];
			if (wb_due[cyc]) begin
				wb_idx  = wb_due_idx[cyc];
				wb_data = wb_due_data[cyc];
				wb_left--;
			end
		end
	end

	initial begin
		int held;
		bit done;
		rst      = 1'b1;
		req_msg  = coh_mem_pkg::MSG_NONE;
		req_idx  = '0;
		req_ptr  = '0;
		req_data = '0;
		for (int i = 0; i < coh_mem_pkg::LINE_NUM; i++) begin
			line_st[i] = ST_I;
			last_st[i] = -1;
		end
		repeat (8) @(posedge clk);
		#2 rst = 1'b0;

		for (int n = 0; n < NUM_REQ; n++) begin
			@(posedge clk);
			#2;
			req_msg  = coh_mem_pkg::bus_msg_e'(2'($random(seed)));
			req_idx  = $random(seed);
			req_ptr  = $random(seed);
			req_data = {$random(seed), $random(seed)};
			held = 0;
			done = 1'b0;
			while (!done) begin
				@(negedge clk);
				held++;
				if (req_ack || held == 3) begin
					done = 1'b1;
				end else begin
					@(posedge clk);
					#2;
				end
			end
		end
		@(posedge clk);
		#2 req_msg = coh_mem_pkg::MSG_NONE;

		while (exp_ptr.size() > 0 || wb_left > 0)
			@(posedge clk);
		repeat (4 * coh_mem_pkg::MEM_LATENCY) @(posedge clk);  // quiet window for stray data
		#2;
		if (DUT.u_chk.fail_cnt == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
hdl/coh_mem_pkg.sv
hdl/coh_line_dir.sv
hdl/mem_issue_q.sv
hdl/mem_rsp_q.sv
hdl/tagged_dmem.sv
hdl/coh_mem_top.sv
tb/coh_mem_chk.sv
tb/coh_mem_tb.sv

// File: Bender.yml
package:
  name: coh_mem

sources:
  - hdl/coh_mem_pkg.sv
  - hdl/coh_line_dir.sv
  - hdl/mem_issue_q.sv
  - hdl/mem_rsp_q.sv
  - hdl/tagged_dmem.sv
  - hdl/coh_mem_top.sv
  - target: test
    files:
      - tb/coh_mem_chk.sv
      - tb/coh_mem_tb.sv
